// ==== logic/avr_io_pkg.sv ====
package avr_io_pkg;

	typedef logic [7:0]  data_t;
	typedef logic [11:0] addr_t;      // Data-space address
	typedef logic [5:0]  irq_vec_t;   // Vector number as on irqackad

	// B 7:0, C 14:8, bit 15 tied low, D 23:16, E 27:24
	typedef logic [27:0] pcint_vec_t;

	localparam int PORT_B_W = 8;
	localparam int PORT_C_W = 7;
	localparam int PORT_D_W = 8;
	localparam int PORT_E_W = 4;

	// Port bases, DDRx at +1 and PORTx at +2
	localparam addr_t PINB_ADDR = 12'h023;
	localparam addr_t PINC_ADDR = 12'h026;
	localparam addr_t PIND_ADDR = 12'h029;
	localparam addr_t PINE_ADDR = 12'h02C;

	localparam addr_t PCIFR_ADDR  = 12'h03B;
	localparam addr_t PCICR_ADDR  = 12'h068;
	localparam addr_t PCMSK0_ADDR = 12'h06B;
	localparam addr_t PCMSK1_ADDR = 12'h06C;
	localparam addr_t PCMSK2_ADDR = 12'h06D;
	localparam addr_t PCMSK3_ADDR = 12'h073;

	localparam int PCINT_GROUPS = 4;

	// Group 3 sits far up the vector table
	localparam irq_vec_t [PCINT_GROUPS-1:0] PCINT_VEC = {6'd27, 6'd5, 6'd4, 6'd3};

endpackage

// ==== logic/io_bus_if.sv ====
`timescale 1ns/1ns

interface io_bus_if import avr_io_pkg::*; ();

	addr_t addr;
	logic  re;
	logic  we;
	data_t wdata;

	modport host (
		output addr,
		output re,
		output we,
		output wdata
	);

	modport periph (
		input addr,
		input re,
		input we,
		input wdata
	);

endinterface

// ==== logic/gpio_port.sv ====
`timescale 1ns/1ns

module gpio_port import avr_io_pkg::*; #(
	parameter int    WIDTH    = 8,
	parameter addr_t PIN_ADDR = PINB_ADDR
) (
	input  logic             clk_i,
	input  logic             arst_n_i,
	io_bus_if.periph         bus,
	input  logic [WIDTH-1:0] pin_i,
	output logic [WIDTH-1:0] pin_sync_o,
	output logic [WIDTH-1:0] pu_o,
	output logic [WIDTH-1:0] dd_o,
	output logic [WIDTH-1:0] pv_o,
	output data_t            rdata_o,
	output logic             rd_en_o
);

	logic [WIDTH-1:0] ddr_q;
	logic [WIDTH-1:0] port_q;
	logic [WIDTH-1:0] sync_q1;
	logic [WIDTH-1:0] sync_q2;
	logic             sel_pin;
	logic             sel_ddr;
	logic             sel_port;

	assign sel_pin  = (bus.addr == PIN_ADDR);
	assign sel_ddr  = (bus.addr == addr_t'(PIN_ADDR + 1));
	assign sel_port = (bus.addr == addr_t'(PIN_ADDR + 2));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ddr_q  <= '0;
			port_q <= '0;
		end else if (bus.we) begin
			if (sel_ddr)
				ddr_q <= bus.wdata[WIDTH-1:0];
			if (sel_port)
				port_q <= bus.wdata[WIDTH-1:0];
		end
	end

	// Two-stage pin synchronizer
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= pin_i;
			sync_q2 <= sync_q1;
		end
	end

	assign pin_sync_o = sync_q2;
	assign dd_o       = ddr_q;
	assign pv_o       = port_q;
	assign pu_o       = port_q & ~ddr_q;   // Pull-up on inputs only

	always_comb begin
		rdata_o = '0;
		if (sel_pin)
			rdata_o = data_t'(sync_q2);
		else if (sel_ddr)
			rdata_o = data_t'(ddr_q);
		else if (sel_port)
			rdata_o = data_t'(port_q);
	end

	assign rd_en_o = bus.re && (sel_pin || sel_ddr || sel_port);

	assert property (@(posedge clk_i) disable iff (!arst_n_i) !(bus.re && bus.we))
		else $error("gpio_port: read and write strobes active together");

endmodule

// ==== logic/pcint_regs.sv ====
`timescale 1ns/1ns

module pcint_regs import avr_io_pkg::*; (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	io_bus_if.periph                bus,
	input  logic [PCINT_GROUPS-1:0] flags_i,
	output logic [PCINT_GROUPS-1:0] pcie_o,
	output pcint_vec_t              pcmsk_o,
	output logic [PCINT_GROUPS-1:0] flag_clr_o,
	output data_t                   rdata_o,
	output logic                    rd_en_o
);

	logic [PCINT_GROUPS-1:0] pcicr_q;
	logic [PORT_B_W-1:0]     pcmsk0_q;
	logic [PORT_C_W-1:0]     pcmsk1_q;
	logic [PORT_D_W-1:0]     pcmsk2_q;
	logic [PORT_E_W-1:0]     pcmsk3_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pcicr_q  <= '0;
			pcmsk0_q <= '0;
			pcmsk1_q <= '0;
			pcmsk2_q <= '0;
			pcmsk3_q <= '0;
		end else if (bus.we) begin
			case (bus.addr)
				PCICR_ADDR:  pcicr_q  <= bus.wdata[PCINT_GROUPS-1:0];
				PCMSK0_ADDR: pcmsk0_q <= bus.wdata[PORT_B_W-1:0];
				PCMSK1_ADDR: pcmsk1_q <= bus.wdata[PORT_C_W-1:0];
				PCMSK2_ADDR: pcmsk2_q <= bus.wdata[PORT_D_W-1:0];
				PCMSK3_ADDR: pcmsk3_q <= bus.wdata[PORT_E_W-1:0];
				default: ;
			endcase
		end
	end

	assign pcie_o  = pcicr_q;
	assign pcmsk_o = {pcmsk3_q, pcmsk2_q, 1'b0, pcmsk1_q, pcmsk0_q};

	// Write one to clear, lasts as long as the write strobe
	assign flag_clr_o = (bus.we && bus.addr == PCIFR_ADDR) ?
		bus.wdata[PCINT_GROUPS-1:0] : '0;

	always_comb begin
		rd_en_o = bus.re;
		rdata_o = '0;
		case (bus.addr)
			PCIFR_ADDR:  rdata_o = data_t'(flags_i);
			PCICR_ADDR:  rdata_o = data_t'(pcicr_q);
			PCMSK0_ADDR: rdata_o = data_t'(pcmsk0_q);
			PCMSK1_ADDR: rdata_o = data_t'(pcmsk1_q);
			PCMSK2_ADDR: rdata_o = data_t'(pcmsk2_q);
			PCMSK3_ADDR: rdata_o = data_t'(pcmsk3_q);
			default:     rd_en_o = 1'b0;
		endcase
	end

endmodule

// ==== logic/pcint_detect.sv ====
`timescale 1ns/1ns

module pcint_detect import avr_io_pkg::*; (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  pcint_vec_t              pins_i,
	input  logic [PCINT_GROUPS-1:0] pcie_i,
	input  pcint_vec_t              pcmsk_i,
	input  logic [PCINT_GROUPS-1:0] flag_clr_i,
	input  logic                    irq_ack_i,
	input  irq_vec_t                irq_ack_addr_i,
	output logic [PCINT_GROUPS-1:0] flags_o,
	output logic [PCINT_GROUPS-1:0] irq_o
);

	pcint_vec_t              pins_q;
	pcint_vec_t              change;
	logic [PCINT_GROUPS-1:0] grp_set;
	logic [PCINT_GROUPS-1:0] ack_clr;
	logic [PCINT_GROUPS-1:0] flags_q;

	assign change = (pins_i ^ pins_q) & pcmsk_i;

	// Group boundaries follow the port layout of the vector
	assign grp_set = {|change[27:24], |change[23:16], |change[15:8], |change[7:0]};

	always_comb begin
		for (int g = 0; g < PCINT_GROUPS; g++) begin
			ack_clr[g] = irq_ack_i && (irq_ack_addr_i == PCINT_VEC[g]);
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pins_q  <= '0;
			flags_q <= '0;
		end else begin
			pins_q  <= pins_i;
			flags_q <= grp_set | (flags_q & ~(ack_clr | flag_clr_i));   // Set wins
		end
	end

	assign flags_o = flags_q;
	assign irq_o   = flags_q & pcie_i;

	// Bit 15 has no pin behind it, group 1 would see a false change
	assert property (@(posedge clk_i) disable iff (!arst_n_i) !pins_i[15] && !pcmsk_i[15])
		else $error("pcint_detect: bit 15 of the pin-change vector is not low");

endmodule

// ==== logic/io_read_mux.sv ====
`timescale 1ns/1ns

module io_read_mux import avr_io_pkg::*; (
	input  data_t      rdata_b_i,
	input  data_t      rdata_c_i,
	input  data_t      rdata_d_i,
	input  data_t      rdata_e_i,
	input  data_t      rdata_pc_i,
	input  logic [4:0] rd_en_i,    // B, C, D, E, pin-change from bit 0
	output data_t      rdata_o
);

	always_comb begin
		rdata_o = rd_en_i[0] ? rdata_b_i  :
		          rd_en_i[1] ? rdata_c_i  :
		          rd_en_i[2] ? rdata_d_i  :
		          rd_en_i[3] ? rdata_e_i  :
		          rd_en_i[4] ? rdata_pc_i :
		          '0;

		// Address map has no overlap
		assert final ($onehot0(rd_en_i))
			else $error("io_read_mux: several read sources enabled");
	end

endmodule

// ==== logic/avr_io_top.sv ====
`timescale 1ns/1ns

module avr_io_top import avr_io_pkg::*; (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  addr_t                   addr_i,
	input  logic                    re_i,
	input  logic                    we_i,
	input  data_t                   wdata_i,
	output data_t                   rdata_o,
	input  logic [PORT_B_W-1:0]     pin_b_i,
	output logic [PORT_B_W-1:0]     pu_b_o,
	output logic [PORT_B_W-1:0]     dd_b_o,
	output logic [PORT_B_W-1:0]     pv_b_o,
	input  logic [PORT_C_W-1:0]     pin_c_i,
	output logic [PORT_C_W-1:0]     pu_c_o,
	output logic [PORT_C_W-1:0]     dd_c_o,
	output logic [PORT_C_W-1:0]     pv_c_o,
	input  logic [PORT_D_W-1:0]     pin_d_i,
	output logic [PORT_D_W-1:0]     pu_d_o,
	output logic [PORT_D_W-1:0]     dd_d_o,
	output logic [PORT_D_W-1:0]     pv_d_o,
	input  logic [PORT_E_W-1:0]     pin_e_i,
	output logic [PORT_E_W-1:0]     pu_e_o,
	output logic [PORT_E_W-1:0]     dd_e_o,
	output logic [PORT_E_W-1:0]     pv_e_o,
	output logic [PCINT_GROUPS-1:0] pcint_irq_o,
	input  logic                    irq_ack_i,
	input  irq_vec_t                irq_ack_addr_i
);

	logic [PORT_B_W-1:0]     sync_b;
	logic [PORT_C_W-1:0]     sync_c;
	logic [PORT_D_W-1:0]     sync_d;
	logic [PORT_E_W-1:0]     sync_e;
	pcint_vec_t              pcint_vec;
	pcint_vec_t              pcmsk;
	logic [PCINT_GROUPS-1:0] pcie;
	logic [PCINT_GROUPS-1:0] flag_clr;
	logic [PCINT_GROUPS-1:0] flags;
	data_t                   rdata_b;
	data_t                   rdata_c;
	data_t                   rdata_d;
	data_t                   rdata_e;
	data_t                   rdata_pc;
	logic [4:0]              rd_en;

	io_bus_if bus ();

	assign bus.addr  = addr_i;
	assign bus.re    = re_i;
	assign bus.we    = we_i;
	assign bus.wdata = wdata_i;

	assign pcint_vec = {sync_e, sync_d, 1'b0, sync_c, sync_b};   // Bit 15 unused

	gpio_port #(.WIDTH(PORT_B_W), .PIN_ADDR(PINB_ADDR)) u_port_b (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bus(bus), .pin_i(pin_b_i),
		.pin_sync_o(sync_b), .pu_o(pu_b_o), .dd_o(dd_b_o), .pv_o(pv_b_o),
		.rdata_o(rdata_b), .rd_en_o(rd_en[0])
	);

	gpio_port #(.WIDTH(PORT_C_W), .PIN_ADDR(PINC_ADDR)) u_port_c (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bus(bus), .pin_i(pin_c_i),
		.pin_sync_o(sync_c), .pu_o(pu_c_o), .dd_o(dd_c_o), .pv_o(pv_c_o),
		.rdata_o(rdata_c), .rd_en_o(rd_en[1])
	);

	gpio_port #(.WIDTH(PORT_D_W), .PIN_ADDR(PIND_ADDR)) u_port_d (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bus(bus), .pin_i(pin_d_i),
		.pin_sync_o(sync_d), .pu_o(pu_d_o), .dd_o(dd_d_o), .pv_o(pv_d_o),
		.rdata_o(rdata_d), .rd_en_o(rd_en[2])
	);

	gpio_port #(.WIDTH(PORT_E_W), .PIN_ADDR(PINE_ADDR)) u_port_e (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bus(bus), .pin_i(pin_e_i),
		.pin_sync_o(sync_e), .pu_o(pu_e_o), .dd_o(dd_e_o), .pv_o(pv_e_o),
		.rdata_o(rdata_e), .rd_en_o(rd_en[3])
	);

	pcint_regs u_pcint_regs (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bus(bus), .flags_i(flags),
		.pcie_o(pcie), .pcmsk_o(pcmsk), .flag_clr_o(flag_clr),
		.rdata_o(rdata_pc), .rd_en_o(rd_en[4])
	);

	pcint_detect u_pcint_detect (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .pins_i(pcint_vec), .pcie_i(pcie),
		.pcmsk_i(pcmsk), .flag_clr_i(flag_clr), .irq_ack_i(irq_ack_i),
		.irq_ack_addr_i(irq_ack_addr_i), .flags_o(flags), .irq_o(pcint_irq_o)
	);

	io_read_mux u_read_mux (
		.rdata_b_i(rdata_b), .rdata_c_i(rdata_c), .rdata_d_i(rdata_d),
		.rdata_e_i(rdata_e), .rdata_pc_i(rdata_pc), .rd_en_i(rd_en),
		.rdata_o(rdata_o)
	);

endmodule

// ==== tb/tb_avr_io.sv ====
`timescale 1ns/1ns

module tb_avr_io import avr_io_pkg::*; ();

	localparam int TIMEOUT = 40;
	localparam logic [3:0][11:0] PBASE = {PINE_ADDR, PIND_ADDR, PINC_ADDR, PINB_ADDR};
	localparam logic [3:0][11:0] MBASE = {PCMSK3_ADDR, PCMSK2_ADDR, PCMSK1_ADDR, PCMSK0_ADDR};
	localparam logic [3:0][7:0]  PMASK = {data_t'((1 << PORT_E_W) - 1),
		data_t'((1 << PORT_D_W) - 1), data_t'((1 << PORT_C_W) - 1), data_t'((1 << PORT_B_W) - 1)};

	logic                    clk_i;
	logic                    arst_n_i;
	addr_t                   addr_i;
	logic                    re_i;
	logic                    we_i;
	data_t                   wdata_i;
	data_t                   rdata_o;
	logic [PORT_B_W-1:0]     pin_b_i, pu_b_o, dd_b_o, pv_b_o;
	logic [PORT_C_W-1:0]     pin_c_i, pu_c_o, dd_c_o, pv_c_o;
	logic [PORT_D_W-1:0]     pin_d_i, pu_d_o, dd_d_o, pv_d_o;
	logic [PORT_E_W-1:0]     pin_e_i, pu_e_o, dd_e_o, pv_e_o;
	logic [PCINT_GROUPS-1:0] pcint_irq_o;
	logic                    irq_ack_i;
	irq_vec_t                irq_ack_addr_i;

	// Shadow copy of the DUT state, one byte lane per port
	logic [3:0][7:0] ddr_sh;
	logic [3:0][7:0] port_sh;
	logic [3:0][7:0] pcmsk_sh;
	logic [3:0]      pcicr_sh;
	logic [3:0]      flags_sh;
	pcint_vec_t      pins_sh;
	logic [3:0][7:0] dd_got;
	logic [3:0][7:0] pv_got;
	logic [3:0][7:0] pu_got;
	logic [31:0]     lfsr;
	logic            settling;   // Flag may be in flight
	int              errors;
	string           pnames = "bcde";

	avr_io_top uut (.*);

	assign dd_got = {data_t'(dd_e_o), data_t'(dd_d_o), data_t'(dd_c_o), data_t'(dd_b_o)};
	assign pv_got = {data_t'(pv_e_o), data_t'(pv_d_o), data_t'(pv_c_o), data_t'(pv_b_o)};
	assign pu_got = {data_t'(pu_e_o), data_t'(pu_d_o), data_t'(pu_c_o), data_t'(pu_b_o)};

	always #4 clk_i = ~clk_i;

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected read data for any address
	function automatic data_t ref_read(addr_t a);
		data_t r;
		r = '0;
		for (int p = 0; p < 4; p++) begin
			if (a == PBASE[p]) r = data_t'(pins_sh >> (p * 8)) & PMASK[p];
			if (a == PBASE[p] + 1) r = ddr_sh[p];
			if (a == PBASE[p] + 2) r = port_sh[p];
			if (a == MBASE[p]) r = pcmsk_sh[p];
		end
		if (a == PCICR_ADDR) r = data_t'(pcicr_sh);
		if (a == PCIFR_ADDR) r = data_t'(flags_sh);
		return r;
	endfunction

	// Any masked bit of a group that changes sets its flag
	function automatic logic [3:0] ref_flags(pcint_vec_t nv);
		logic [3:0] f;
		f = flags_sh;
		for (int g = 0; g < PCINT_GROUPS; g++)
			if ((data_t'((nv ^ pins_sh) >> (g * 8)) & pcmsk_sh[g]) != 0) f[g] = 1'b1;
		return f;
	endfunction

	task automatic mismatch(string name, data_t got, data_t exp);
		errors++;
		$display("MISMATCH %s got %h expected %h", name, got, exp);
	endtask

	task automatic read_byte(addr_t a, output data_t d);
		@(posedge clk_i);
		addr_i <= a;
		re_i   <= 1'b1;
		we_i   <= 1'b0;
		@(negedge clk_i);
		d = rdata_o;
	endtask

	task automatic check_read(addr_t a);
		data_t d;
		read_byte(a, d);
		assert (d === ref_read(a))
			else mismatch($sformatf("rdata_o at %h", a), d, ref_read(a));
	endtask

	task automatic wait_read(addr_t a, data_t exp);
		data_t d;
		int    n;
		n = 0;
		do begin
			read_byte(a, d);
			n++;
		end while (d !== exp && n < TIMEOUT);
		assert (d === exp) else begin
			errors++;
			$display("Timed out waiting for address %h to read %h, last read %h", a, exp, d);
		end
	endtask

	task automatic write_reg(addr_t a, data_t d);
		@(posedge clk_i);
		addr_i  <= a;
		wdata_i <= d;
		we_i    <= 1'b1;
		re_i    <= 1'b0;
		@(posedge clk_i);
		we_i <= 1'b0;
		for (int p = 0; p < 4; p++) begin
			if (a == PBASE[p] + 1) ddr_sh[p] = d & PMASK[p];
			if (a == PBASE[p] + 2) port_sh[p] = d & PMASK[p];
			if (a == MBASE[p]) pcmsk_sh[p] = d & PMASK[p];
		end
		if (a == PCICR_ADDR) pcicr_sh = d[3:0];
		if (a == PCIFR_ADDR) flags_sh = flags_sh & ~d[3:0];   // Write one to clear
	endtask

	task automatic ack_vec(irq_vec_t v);
		@(posedge clk_i);
		irq_ack_i      <= 1'b1;
		irq_ack_addr_i <= v;
		@(posedge clk_i);
		irq_ack_i <= 1'b0;
		for (int g = 0; g < PCINT_GROUPS; g++)
			if (PCINT_VEC[g] == v) flags_sh[g] = 1'b0;
	endtask

	task automatic change_pins(pcint_vec_t nv);
		nv[15] = 1'b0;
		settling = 1'b1;
		@(posedge clk_i);
		pin_b_i <= nv[7:0];
		pin_c_i <= nv[14:8];
		pin_d_i <= nv[23:16];
		pin_e_i <= nv[27:24];
		flags_sh = ref_flags(nv);
		pins_sh = nv;
		for (int p = 0; p < 4; p++)
			wait_read(PBASE[p], ref_read(PBASE[p]));
		wait_read(PCIFR_ADDR, ref_read(PCIFR_ADDR));
		repeat (3) @(posedge clk_i);   // Past the edge where a late flag would set
		settling = 1'b0;
		check_read(PCIFR_ADDR);
	endtask

	// Pads and requests against the shadow state
	always @(negedge clk_i) begin
		if (arst_n_i) begin
			for (int p = 0; p < 4; p++) begin
				assert (dd_got[p] === ddr_sh[p])
					else mismatch($sformatf("dd_%c_o", pnames[p]), dd_got[p], ddr_sh[p]);
				assert (pv_got[p] === port_sh[p])
					else mismatch($sformatf("pv_%c_o", pnames[p]), pv_got[p], port_sh[p]);
				assert (pu_got[p] === (port_sh[p] & ~ddr_sh[p]))
					else mismatch($sformatf("pu_%c_o", pnames[p]), pu_got[p],
						port_sh[p] & ~ddr_sh[p]);
			end
			if (!settling)
				assert (pcint_irq_o === (flags_sh & pcicr_sh))
					else mismatch("pcint_irq_o", data_t'(pcint_irq_o),
						data_t'(flags_sh & pcicr_sh));
		end
	end

	initial begin
		clk_i          = 1'b0;
		arst_n_i       = 1'b0;
		addr_i         = '0;
		re_i           = 1'b0;
		we_i           = 1'b0;
		wdata_i        = '0;
		pin_b_i        = '0;
		pin_c_i        = '0;
		pin_d_i        = '0;
		pin_e_i        = '0;
		irq_ack_i      = 1'b0;
		irq_ack_addr_i = '0;
		ddr_sh         = '0;
		port_sh        = '0;
		pcmsk_sh       = '0;
		pcicr_sh       = '0;
		flags_sh       = '0;
		pins_sh        = '0;
		settling       = 1'b0;
		errors         = 0;
		lfsr           = 32'h6ea1;

		repeat (10) @(posedge clk_i);
		arst_n_i <= 1'b1;

		// Reset values and two holes in the map
		for (int p = 0; p < 4; p++) begin
			check_read(PBASE[p]);
			check_read(addr_t'(PBASE[p] + 1));
			check_read(addr_t'(PBASE[p] + 2));
			check_read(MBASE[p]);
		end
		check_read(PCICR_ADDR);
		check_read(PCIFR_ADDR);
		check_read(12'h02F);
		check_read(12'h0FF);

		repeat (6) begin
			for (int p = 0; p < 4; p++) begin
				write_reg(addr_t'(PBASE[p] + 1), data_t'(rand_bits(8)));
				write_reg(addr_t'(PBASE[p] + 2), data_t'(rand_bits(8)));
				check_read(addr_t'(PBASE[p] + 1));
				check_read(addr_t'(PBASE[p] + 2));
			end
		end

		repeat (5) change_pins(pcint_vec_t'(rand_bits(28)));

		// Bit 0 of each group masked, bit 1 left open
		write_reg(PCICR_ADDR, 8'h0F);
		for (int g = 0; g < PCINT_GROUPS; g++) begin
			write_reg(MBASE[g], 8'h01);
			check_read(MBASE[g]);
			change_pins(pins_sh ^ (pcint_vec_t'(2) << (g * 8)));
			change_pins(pins_sh ^ (pcint_vec_t'(1) << (g * 8)));
		end

		ack_vec(PCINT_VEC[1]);
		check_read(PCIFR_ADDR);
		ack_vec(6'd6);
		check_read(PCIFR_ADDR);
		ack_vec(PCINT_VEC[3]);
		write_reg(PCIFR_ADDR, 8'h01);
		check_read(PCIFR_ADDR);
		write_reg(PCIFR_ADDR, 8'h04);
		check_read(PCIFR_ADDR);

		// Flag sets with the request disabled
		write_reg(PCICR_ADDR, 8'h00);
		change_pins(pins_sh ^ (pcint_vec_t'(1) << 16));
		write_reg(PCIFR_ADDR, 8'h0F);
		check_read(PCIFR_ADDR);
		repeat (2) @(posedge clk_i);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== avr_io_subsystem.f ====
logic/avr_io_pkg.sv
logic/io_bus_if.sv
logic/gpio_port.sv
logic/pcint_regs.sv
logic/pcint_detect.sv
logic/io_read_mux.sv
logic/avr_io_top.sv
tb/tb_avr_io.sv

// ==== Bender.yml ====
package:
  name: avr_io_subsystem

sources:
  - logic/avr_io_pkg.sv
  - logic/io_bus_if.sv
  - logic/gpio_port.sv
  - logic/pcint_regs.sv
  - logic/pcint_detect.sv
  - logic/io_read_mux.sv
  - logic/avr_io_top.sv
  - target: simulation
    files:
      - tb/tb_avr_io.sv
